// ==== verilog/mips_pkg.sv ====
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;

	// Primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_SLTI  = 6'b001010;
	localparam logic [5:0] OP_ORI   = 6'b001101;
	localparam logic [5:0] OP_XORI  = 6'b001110;
	localparam logic [5:0] OP_LUI   = 6'b001111;
	localparam logic [5:0] OP_LW    = 6'b100011;
	localparam logic [5:0] OP_SW    = 6'b101011;

	// R-type function field
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI
	} alu_op_t;

	typedef struct packed {
		word_t    a;
		word_t    b;         // rt or extended immediate
		word_t    st_data;   // rt value for SW
		logic [4:0] shamt;
		alu_op_t  alu_op;
		reg_idx_t rd;
		logic     reg_write;
		logic     mem_write;
		logic     mem_read;
	} dx_payload_t;

	typedef struct packed {
		word_t    result;
		word_t    st_data;
		reg_idx_t rd;
		logic     reg_write;
		logic     mem_write;
		logic     mem_read;
	} xm_payload_t;

	typedef struct packed {
		word_t    value;
		reg_idx_t rd;
		logic     reg_write;
	} mw_payload_t;

endpackage

// ==== verilog/stage_reg.sv ====
module stage_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     in_valid,
	input  payload_t in_payload,
	output logic     out_valid,
	output payload_t out_payload
);

	always_ff @(posedge clock) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
		out_payload <= in_payload;
	end

endmodule

// ==== verilog/register_file.sv ====
module register_file import mips_pkg::*; (
	input  logic     clock,
	input  logic     rst_n,
	input  reg_idx_t rs_idx,
	input  reg_idx_t rt_idx,
	output word_t    rs_data,
	output word_t    rt_data,
	input  logic     we,
	input  reg_idx_t wr_idx,
	input  word_t    wr_data
);

	word_t regs [32];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wr_idx != 5'd0) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Write-through so writeback and decode can share a cycle
	always_comb begin
		if (rs_idx == 5'd0)
			rs_data = '0;
		else if (we && wr_idx == rs_idx)
			rs_data = wr_data;
		else
			rs_data = regs[rs_idx];

		if (rt_idx == 5'd0)
			rt_data = '0;
		else if (we && wr_idx == rt_idx)
			rt_data = wr_data;
		else
			rt_data = regs[rt_idx];
	end

endmodule

// ==== verilog/alu.sv ====
module alu import mips_pkg::*; (
	input  alu_op_t    op,
	input  word_t      a,
	input  word_t      b,
	input  logic [4:0] shamt,
	output word_t      result
);

	logic signed_lt;
	logic unsigned_lt;

	assign signed_lt   = $signed(a) < $signed(b);
	assign unsigned_lt = a < b;

	always_comb begin
		case (op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_XOR:  result = a ^ b;
			ALU_NOR:  result = ~(a | b);
			ALU_SLT:  result = {31'b0, signed_lt};
			ALU_SLTU: result = {31'b0, unsigned_lt};
			// Shifts work on the rt operand
			ALU_SLL:  result = b << shamt;
			ALU_SRL:  result = b >> shamt;
			ALU_SRA:  result = word_t'($signed(b) >>> shamt);
			ALU_LUI:  result = {b[15:0], 16'h0000};
			default:  result = '0;
		endcase
	end

endmodule

// ==== verilog/data_memory.sv ====
module data_memory import mips_pkg::*; #(
	parameter int DMEM_DEPTH = 64
) (
	input  logic  clock,
	input  logic  we,
	input  word_t addr,
	input  word_t wdata,
	output word_t rdata
);

	localparam int AW = $clog2(DMEM_DEPTH);

	word_t mem [DMEM_DEPTH];
	logic [AW-1:0] idx;

	assign idx = addr[AW+1:2]; // Word index, byte offset ignored

	always_ff @(posedge clock) begin
		if (we)
			mem[idx] <= wdata;
	end

	assign rdata = mem[idx];

endmodule

// ==== verilog/decode_unit.sv ====
module decode_unit import mips_pkg::*; (
	input  word_t       insn,
	input  logic        insn_valid,
	output reg_idx_t    rs_idx,
	output reg_idx_t    rt_idx,
	input  word_t       rs_data,
	input  word_t       rt_data,
	output dx_payload_t payload,
	output logic        payload_valid
);

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_idx_t   rd_field;
	logic [15:0] imm;
	word_t      imm_sext;
	word_t      imm_zext;
	logic       known;

	assign opcode   = insn[31:26];
	assign rs_idx   = insn[25:21];
	assign rt_idx   = insn[20:16];
	assign rd_field = insn[15:11];
	assign funct    = insn[5:0];
	assign imm      = insn[15:0];

	assign imm_sext = {{16{imm[15]}}, imm};
	assign imm_zext = {16'h0000, imm};

	always_comb begin
		payload.a         = rs_data;
		payload.b         = rt_data;
		payload.st_data   = rt_data;
		payload.shamt     = insn[10:6];
		payload.alu_op    = ALU_ADD;
		payload.rd        = rt_idx; // I-type writes rt
		payload.reg_write = 1'b0;
		payload.mem_write = 1'b0;
		payload.mem_read  = 1'b0;
		known = 1'b1;

		case (opcode)
			OP_RTYPE: begin
				payload.rd        = rd_field;
				payload.reg_write = 1'b1;
				case (funct)
					FN_ADDU: payload.alu_op = ALU_ADD;
					FN_SUBU: payload.alu_op = ALU_SUB;
					FN_AND:  payload.alu_op = ALU_AND;
					FN_OR:   payload.alu_op = ALU_OR;
					FN_XOR:  payload.alu_op = ALU_XOR;
					FN_NOR:  payload.alu_op = ALU_NOR;
					FN_SLT:  payload.alu_op = ALU_SLT;
					FN_SLTU: payload.alu_op = ALU_SLTU;
					FN_SLL:  payload.alu_op = ALU_SLL;
					FN_SRL:  payload.alu_op = ALU_SRL;
					FN_SRA:  payload.alu_op = ALU_SRA;
					default: known = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				payload.b         = imm_sext;
				payload.reg_write = 1'b1;
			end
			OP_SLTI: begin
				payload.b         = imm_sext;
				payload.alu_op    = ALU_SLT;
				payload.reg_write = 1'b1;
			end
			OP_ORI: begin
				payload.b         = imm_zext;
				payload.alu_op    = ALU_OR;
				payload.reg_write = 1'b1;
			end
			OP_XORI: begin
				payload.b         = imm_zext;
				payload.alu_op    = ALU_XOR;
				payload.reg_write = 1'b1;
			end
			OP_LUI: begin
				payload.b         = imm_zext;
				payload.alu_op    = ALU_LUI;
				payload.reg_write = 1'b1;
			end
			OP_LW: begin
				payload.b         = imm_sext; // Base plus offset
				payload.mem_read  = 1'b1;
				payload.reg_write = 1'b1;
			end
			OP_SW: begin
				payload.b         = imm_sext;
				payload.mem_write = 1'b1;
			end
			default: known = 1'b0;
		endcase
	end

	// Unknown encodings drop out as bubbles
	assign payload_valid = insn_valid && known;

endmodule

// ==== verilog/fetch_unit.sv ====
module fetch_unit import mips_pkg::*; #(
	parameter int IMEM_DEPTH = 64
) (
	input  logic                            clock,
	input  logic                            rst_n,
	input  logic                            imem_we,
	input  logic [$clog2(IMEM_DEPTH)-1:0]   imem_addr,
	input  word_t                           imem_data,
	input  logic                            start,
	input  logic [$clog2(IMEM_DEPTH+1)-1:0] prog_len,
	output word_t                           insn,
	output logic                            insn_valid,
	output logic                            busy
);

	localparam int AW = $clog2(IMEM_DEPTH);
	localparam int LW = $clog2(IMEM_DEPTH + 1);
	localparam logic [1:0] DRAIN_LAST = 2'd3; // Four cycles after last issue

	word_t imem [IMEM_DEPTH];

	logic [LW-1:0] pc;
	logic [LW-1:0] len;
	logic          issuing;
	logic [1:0]    drain_cnt;

	// Program load, locked out while running
	always_ff @(posedge clock) begin
		if (imem_we && !busy)
			imem[imem_addr] <= imem_data;
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pc        <= '0;
			len       <= '0;
			issuing   <= 1'b0;
			drain_cnt <= 2'd0;
			busy      <= 1'b0;
		end else if (start && !busy) begin
			pc        <= '0;
			len       <= prog_len;
			issuing   <= (prog_len != '0);
			drain_cnt <= DRAIN_LAST;
			busy      <= 1'b1;
		end else if (issuing) begin
			pc <= pc + 1'b1;
			if (pc + 1'b1 == len)
				issuing <= 1'b0; // Last one goes out this cycle
		end else if (busy) begin
			if (drain_cnt == 2'd0)
				busy <= 1'b0;
			else
				drain_cnt <= drain_cnt - 1'b1;
		end
	end

	assign insn       = imem[pc[AW-1:0]];
	assign insn_valid = issuing;

endmodule

// ==== verilog/mips_pipeline.sv ====
module mips_pipeline import mips_pkg::*; #(
	parameter int IMEM_DEPTH = 64,
	parameter int DMEM_DEPTH = 64
) (
	input  logic                            clock,
	input  logic                            rst_n,
	input  logic                            imem_we,
	input  logic [$clog2(IMEM_DEPTH)-1:0]   imem_addr,
	input  word_t                           imem_data,
	input  logic                            start,
	input  logic [$clog2(IMEM_DEPTH+1)-1:0] prog_len,
	output logic                            busy,
	output logic                            retire_valid,
	output reg_idx_t                        retire_rd,
	output word_t                           retire_value,
	output logic                            store_valid,
	output word_t                           store_addr,
	output word_t                           store_data
);

	word_t       insn;
	logic        insn_valid;
	reg_idx_t    rs_idx;
	reg_idx_t    rt_idx;
	word_t       rs_data;
	word_t       rt_data;
	dx_payload_t dx_d, dx_q;
	logic        dx_d_valid, dx_q_valid;
	word_t       alu_result;
	xm_payload_t xm_d, xm_q;
	logic        xm_q_valid;
	word_t       load_data;
	mw_payload_t mw_d, mw_q;
	logic        mw_q_valid;
	logic        rf_we;

	fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
		.clock(clock), .rst_n(rst_n),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
		.start(start), .prog_len(prog_len),
		.insn(insn), .insn_valid(insn_valid), .busy(busy)
	);

	decode_unit u_decode (
		.insn(insn), .insn_valid(insn_valid),
		.rs_idx(rs_idx), .rt_idx(rt_idx), .rs_data(rs_data), .rt_data(rt_data),
		.payload(dx_d), .payload_valid(dx_d_valid)
	);

	register_file u_regs (
		.clock(clock), .rst_n(rst_n),
		.rs_idx(rs_idx), .rt_idx(rt_idx), .rs_data(rs_data), .rt_data(rt_data),
		.we(rf_we), .wr_idx(mw_q.rd), .wr_data(mw_q.value)
	);

	stage_reg #(.payload_t(dx_payload_t)) u_dx (
		.clock(clock), .rst_n(rst_n),
		.in_valid(dx_d_valid), .in_payload(dx_d),
		.out_valid(dx_q_valid), .out_payload(dx_q)
	);

	alu u_alu (
		.op(dx_q.alu_op), .a(dx_q.a), .b(dx_q.b), .shamt(dx_q.shamt),
		.result(alu_result)
	);

	always_comb begin
		xm_d.result    = alu_result; // Address for LW and SW
		xm_d.st_data   = dx_q.st_data;
		xm_d.rd        = dx_q.rd;
		xm_d.reg_write = dx_q.reg_write;
		xm_d.mem_write = dx_q.mem_write;
		xm_d.mem_read  = dx_q.mem_read;
	end

	stage_reg #(.payload_t(xm_payload_t)) u_xm (
		.clock(clock), .rst_n(rst_n),
		.in_valid(dx_q_valid), .in_payload(xm_d),
		.out_valid(xm_q_valid), .out_payload(xm_q)
	);

	data_memory #(.DMEM_DEPTH(DMEM_DEPTH)) u_dmem (
		.clock(clock), .we(store_valid),
		.addr(xm_q.result), .wdata(xm_q.st_data), .rdata(load_data)
	);

	always_comb begin
		mw_d.value     = xm_q.mem_read ? load_data : xm_q.result;
		mw_d.rd        = xm_q.rd;
		mw_d.reg_write = xm_q.reg_write;
	end

	stage_reg #(.payload_t(mw_payload_t)) u_mw (
		.clock(clock), .rst_n(rst_n),
		.in_valid(xm_q_valid), .in_payload(mw_d),
		.out_valid(mw_q_valid), .out_payload(mw_q)
	);

	assign store_valid = xm_q_valid && xm_q.mem_write;
	assign store_addr  = xm_q.result;
	assign store_data  = xm_q.st_data;

	assign rf_we        = mw_q_valid && mw_q.reg_write;
	assign retire_valid = rf_we && (mw_q.rd != 5'd0); // r0 writes are silent
	assign retire_rd    = mw_q.rd;
	assign retire_value = mw_q.value;

endmodule

// ==== tb/mips_pipeline_assert.sv ====
module mips_pipeline_assert (
	input logic        clock,
	input logic        rst_n,
	input logic        busy,
	input logic        retire_valid,
	input logic        store_valid,
	input logic [31:0] store_addr
);

	// Idle straight out of reset
	assert property (@(posedge clock) !rst_n |=> !busy)
		else $error("busy high after reset");

	assert property (@(posedge clock) disable iff (!rst_n) retire_valid |-> busy)
		else $error("register write while the pipeline is idle");

	assert property (@(posedge clock) disable iff (!rst_n) store_valid |-> store_addr[1:0] == 2'b00)
		else $error("store address not word aligned");

endmodule

bind mips_pipeline mips_pipeline_assert u_assert (
	.clock(clock), .rst_n(rst_n), .busy(busy), .retire_valid(retire_valid),
	.store_valid(store_valid), .store_addr(store_addr)
);

// ==== tb/mips_pipeline_tb.sv ====
module mips_pipeline_tb import mips_pkg::*; ();

	localparam int IMEM_DEPTH = 64;
	localparam int DMEM_DEPTH = 64;
	localparam int AW = $clog2(IMEM_DEPTH);
	localparam int LW = $clog2(IMEM_DEPTH + 1);
	localparam int PROG_LEN = 48;
	localparam int NUM_PROGS = 4;
	localparam int RESET_CYCLES = 4;
	localparam int TIMEOUT_CYCLES = NUM_PROGS * (2 * PROG_LEN + 20) + RESET_CYCLES; // Load and run
	localparam logic [10:0][5:0] FN_LIST = {FN_SRA, FN_SRL, FN_SLL, FN_SLTU, FN_SLT,
		FN_NOR, FN_XOR, FN_OR, FN_AND, FN_SUBU, FN_ADDU};

	logic          clock;
	logic          rst_n;
	logic          imem_we;
	logic [AW-1:0] imem_addr;
	word_t         imem_data;
	logic          start;
	logic [LW-1:0] prog_len;
	logic          busy;
	logic          retire_valid;
	reg_idx_t      retire_rd;
	word_t         retire_value;
	logic          store_valid;
	word_t         store_addr;
	word_t         store_data;

	integer   seed;
	int       cycle_count = 0;
	int       retire_ptr = 0;
	int       store_ptr = 0;
	int       retire_errors = 0;
	int       store_errors = 0;
	int       flow_errors = 0;
	word_t    model_regs [32];
	word_t    model_mem [DMEM_DEPTH];
	int       stored_idx [$]; // Slots a LW may read
	word_t    program_words [PROG_LEN];
	reg_idx_t prev_rd1;
	reg_idx_t prev_rd2;
	reg_idx_t exp_rd_q [$];
	word_t    exp_value_q [$];
	word_t    exp_addr_q [$];
	word_t    exp_data_q [$];

	mips_pipeline #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) UUT (
		.clock(clock), .rst_n(rst_n),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
		.start(start), .prog_len(prog_len), .busy(busy),
		.retire_valid(retire_valid), .retire_rd(retire_rd), .retire_value(retire_value),
		.store_valid(store_valid), .store_addr(store_addr), .store_data(store_data)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock)
		cycle_count <= cycle_count + 1;

	initial begin
		while (cycle_count < TIMEOUT_CYCLES)
			@(posedge clock);
		$display("ERROR: timeout after %0d cycles, the pipeline never went idle", cycle_count);
		$display("*** TEST FAILED ***");
		$finish;
	end

	function automatic int rand_below(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// Any register except the last two destinations
	function automatic reg_idx_t pick_src();
		reg_idx_t r;
		r = reg_idx_t'(rand_below(32));
		while (r == prev_rd1 || r == prev_rd2)
			r = reg_idx_t'(rand_below(32));
		return r;
	endfunction

	function automatic word_t ref_rtype(logic [5:0] fn, word_t a, word_t b, logic [4:0] sh);
		case (fn)
			FN_ADDU: return a + b;
			FN_SUBU: return a - b;
			FN_AND:  return a & b;
			FN_OR:   return a | b;
			FN_XOR:  return a ^ b;
			FN_NOR:  return ~(a | b);
			FN_SLT:  return word_t'($signed(a) < $signed(b));
			FN_SLTU: return word_t'(a < b);
			FN_SLL:  return b << sh;
			FN_SRL:  return b >> sh;
			default: return word_t'($signed(b) >>> sh);
		endcase
	endfunction

	task automatic gen_program();
		int          kind;
		int          slot;
		reg_idx_t    rs;
		reg_idx_t    rt;
		reg_idx_t    rd;
		logic [5:0]  fn;
		logic [4:0]  sh;
		logic [15:0] imm;
		prev_rd1 = 5'd0;
		prev_rd2 = 5'd0;
		for (int k = 0; k < PROG_LEN; k++) begin
			kind = rand_below(12);
			rs = pick_src();
			rt = pick_src();
			rd = reg_idx_t'(1 + rand_below(31));
			sh = 5'(rand_below(32));
			imm = 16'(rand_below(65536));
			if (kind == 10 && stored_idx.size() == 0)
				kind = 9; // Nothing stored yet
			case (kind)
				4: begin
					program_words[k] = {OP_ADDIU, rs, rd, imm};
					model_regs[rd] = model_regs[rs] + {{16{imm[15]}}, imm};
				end
				5: begin
					program_words[k] = {OP_SLTI, rs, rd, imm};
					model_regs[rd] = word_t'($signed(model_regs[rs]) < $signed({{16{imm[15]}}, imm}));
				end
				6: begin
					program_words[k] = {OP_ORI, rs, rd, imm};
					model_regs[rd] = model_regs[rs] | {16'h0000, imm};
				end
				7: begin
					program_words[k] = {OP_XORI, rs, rd, imm};
					model_regs[rd] = model_regs[rs] ^ {16'h0000, imm};
				end
				8: begin
					program_words[k] = {OP_LUI, 5'd0, rd, imm};
					model_regs[rd] = {imm, 16'h0000};
				end
				9: begin
					slot = rand_below(DMEM_DEPTH);
					program_words[k] = {OP_SW, 5'd0, rt, 16'(slot * 4)};
					model_mem[slot] = model_regs[rt];
					stored_idx.push_back(slot);
					exp_addr_q.push_back(word_t'(slot * 4));
					exp_data_q.push_back(model_regs[rt]);
					rd = 5'd0; // No register write
				end
				10: begin
					slot = stored_idx[rand_below(stored_idx.size())];
					program_words[k] = {OP_LW, 5'd0, rd, 16'(slot * 4)};
					model_regs[rd] = model_mem[slot];
				end
				default: begin
					fn = FN_LIST[rand_below(11)];
					program_words[k] = {OP_RTYPE, rs, rt, rd, sh, fn};
					model_regs[rd] = ref_rtype(fn, model_regs[rs], model_regs[rt], sh);
				end
			endcase
			if (rd != 5'd0) begin
				exp_rd_q.push_back(rd);
				exp_value_q.push_back(model_regs[rd]);
			end
			prev_rd2 = prev_rd1;
			prev_rd1 = rd;
		end
	endtask

	task automatic load_program();
		for (int i = 0; i < PROG_LEN; i++) begin
			imem_we = 1'b1;
			imem_addr = AW'(i);
			imem_data = program_words[i];
			@(posedge clock);
			#1;
		end
		imem_we = 1'b0;
	endtask

	task automatic run_program();
		int cycles;
		start = 1'b1;
		prog_len = LW'(PROG_LEN);
		@(posedge clock);
		#1;
		start = 1'b0;
		cycles = 1;
		assert (busy) else begin
			flow_errors++;
			$display("ERROR: busy did not rise the cycle after start");
		end
		while (busy) begin
			@(posedge clock);
			#1;
			cycles++;
		end
		assert (cycles == PROG_LEN + 5) else begin
			flow_errors++;
			$display("ERROR: busy fell %0d cycles after start, expected %0d", cycles, PROG_LEN + 5);
		end
		assert (retire_ptr == exp_rd_q.size() && store_ptr == exp_addr_q.size()) else begin
			flow_errors++;
			$display("ERROR: program ended with register writes or stores still missing");
		end
	endtask

	// Strobes come from registers, so the falling edge sees them settled
	always @(negedge clock) begin
		assert (!(retire_valid && retire_ptr >= exp_rd_q.size())) else begin
			retire_errors++;
			$display("ERROR: register write to r%0d that the model did not expect", retire_rd);
		end
		if (retire_valid && retire_ptr < exp_rd_q.size()) begin
			assert (retire_rd == exp_rd_q[retire_ptr]) else begin
				retire_errors++;
				$display("MISMATCH retire_rd: got %h expected %h", retire_rd, exp_rd_q[retire_ptr]);
			end
			assert (retire_value == exp_value_q[retire_ptr]) else begin
				retire_errors++;
				$display("MISMATCH retire_value: got %h expected %h",
					retire_value, exp_value_q[retire_ptr]);
			end
			retire_ptr++;
		end
		assert (!(store_valid && store_ptr >= exp_addr_q.size())) else begin
			store_errors++;
			$display("ERROR: store to address %h that the model did not expect", store_addr);
		end
		if (store_valid && store_ptr < exp_addr_q.size()) begin
			assert (store_addr == exp_addr_q[store_ptr]) else begin
				store_errors++;
				$display("MISMATCH store_addr: got %h expected %h", store_addr, exp_addr_q[store_ptr]);
			end
			assert (store_data == exp_data_q[store_ptr]) else begin
				store_errors++;
				$display("MISMATCH store_data: got %h expected %h", store_data, exp_data_q[store_ptr]);
			end
			store_ptr++;
		end
	end

	initial begin
		rst_n = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		start = 1'b0;
		prog_len = '0;
		seed = 32'h3e98af13;
		model_regs = '{default: '0};
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		rst_n = 1'b1;
		repeat (3) begin
			@(posedge clock);
			#1;
			assert (!busy && !retire_valid && !store_valid) else begin
				flow_errors++;
				$display("ERROR: pipeline active before any start");
			end
		end
		// State carries over from one program to the next
		for (int p = 0; p < NUM_PROGS; p++) begin
			gen_program();
			load_program();
			run_program();
		end
		$display("Checked %0d writes and %0d stores; errors: retire %0d, store %0d, control %0d",
			retire_ptr, store_ptr, retire_errors, store_errors, flow_errors);
		if (retire_errors + store_errors + flow_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== project.f ====
verilog/mips_pkg.sv
verilog/stage_reg.sv
verilog/register_file.sv
verilog/alu.sv
verilog/data_memory.sv
verilog/decode_unit.sv
verilog/fetch_unit.sv
verilog/mips_pipeline.sv
tb/mips_pipeline_assert.sv
tb/mips_pipeline_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f project.f --top-module mips_pipeline_tb -o sim_mips
./obj_dir/sim_mips | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
